// ==== testbench/tape_tests.txt ====
# Tape reader test records, one per line, numbers in hex
# B count bytes | D level | E | X | T | C cycles | W word | M addr data
# S start_addr | R rim_active | V word_valid | N quiet cycles | G gamepad runs
S 004
R 0
V 0
D 1
# Binary word with bytes that lack bit 7 mixed in
B 5 85 12 aa 40 ff
W 05abf
T
B 3 bf 80 a1
W 3f021
T
# Download going low drops a waiting word
B 3 81 82 83
W 01083
D 0
V 0
D 1
# A new download throws away a partial word
B 2 9f 9e
D 0
D 1
B 3 84 88 90
W 04210
T
# rim_disable drops a waiting word
B 3 87 87 87
W 071c7
X
V 0
R 0
# Read-in mode with three dio lines in a row
E
R 1
B 7 9a 81 3a 80 8a 9c ae
M 040 0a72e
B 6 9a 81 81 bf b8 80
M 041 3fe00
B 6 9a bf bf 80 80 81
M fff 00001
# Opcode 20 is neither dio nor jmp
B 6 90 81 81 81 81 81
N 4
R 1
# jmp sets the start address, leaves read-in and offers its data word
B 6 b0 82 80 b0 82 80
W 30080
S 080
R 0
T
# Binary mode again after the jmp
B 3 a5 9b 8c
W 256cc
T
C 2
G 80

// ==== build.f ====
+incdir+rtl
rtl/pdp1_tape_pkg.sv
rtl/tape_line_if.sv
rtl/tape_frame_assembler.sv
rtl/tape_loader.sv
rtl/spacewar_gamepad.sv
rtl/pdp1_tape_top.sv
testbench/pdp1_tape_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the tape reader testbench with Verilator, runs it and judges the log
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f build.f --top-module pdp1_tape_tb \
   --Mdir "$build_dir" -o pdp1_tape_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$build_dir/pdp1_tape_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qF '** FAIL **' "$log_file"; then
   echo "Simulation reported a failure"
   exit 1
fi

echo "Simulation log shows no failure"
exit 0

// ==== testbench/pdp1_tape_tb.sv ====
// Self-checking testbench for the PDP-1 tape reader front end and the Spacewar gamepad
`default_nettype none
`timescale 1ns/1ps

`include "pdp1_tape_defines.svh"

module pdp1_tape_tb;

   localparam string TEST_FILE         = "testbench/tape_tests.txt";
   // Longest wait for any expected event, in clock cycles
   localparam int    WAIT_CYCLES       = 40;
   localparam int    CYCLES_PER_RECORD = 200;

   logic                       CLK_50M;
   logic                       arst_n;
   logic                       tape_download;
   logic                       tape_wr;
   logic [7:0]                 tape_byte;
   logic                       tape_wait;
   logic                       rim_enable;
   logic                       rim_disable;
   logic                       rim_active;
   logic                       word_valid;
   logic [`PDP1_WORD_BITS-1:0] word;
   logic                       word_taken;
   logic                       mem_wr;
   logic [`PDP1_ADDR_BITS-1:0] mem_addr;
   logic [`PDP1_WORD_BITS-1:0] mem_data;
   logic [`PDP1_ADDR_BITS-1:0] start_addr;
   logic [15:0]                joystick_0;
   logic [15:0]                joystick_1;
   logic [`PDP1_WORD_BITS-1:0] io_word;

   int value_errors = 0;
   int other_errors = 0;
   int record_lines = 0;

   pdp1_tape_top dut_i (.*);

   // 50 MHz clock
   always #10 CLK_50M = ~CLK_50M;

   // ======================================================================
   // Reporting
   // ======================================================================
   task automatic report_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("FAIL t=%0t %s: expected %0h, got %0h", $time, name, expected, actual);
      value_errors++;
   endtask

   task automatic report_problem(input string what);
      $display("ERROR t=%0t %s", $time, what);
      other_errors++;
   endtask

   // ======================================================================
   // Tape source and CPU side
   // ======================================================================

   // The source holds off while the reader asks it to wait
   task automatic send_byte(input logic [7:0] value);
      int n;
      for (n = 0; n < WAIT_CYCLES && tape_wait; n++) @(negedge CLK_50M);
      if (tape_wait) begin
         report_problem("tape_wait never fell, a tape byte could not be sent");
      end else begin
         tape_byte = value;
         tape_wr   = 1'b1;
         @(negedge CLK_50M);
         tape_wr   = 1'b0;
      end
   endtask

   task automatic set_download(input logic level);
      tape_download = level;
      @(negedge CLK_50M);
   endtask

   // One-cycle pulse on rim_enable or on rim_disable
   task automatic pulse_mode(input logic enable);
      rim_enable  = enable;
      rim_disable = !enable;
      @(negedge CLK_50M);
      rim_enable  = 1'b0;
      rim_disable = 1'b0;
   endtask

   // A word is offered and must sit still, with the source held off, until taken
   task automatic expect_word(input logic [31:0] expected);
      int                         n;
      logic [`PDP1_WORD_BITS-1:0] held;
      for (n = 0; n < WAIT_CYCLES && !word_valid; n++) @(negedge CLK_50M);
      if (!word_valid) begin
         report_problem("word_valid never rose for an expected word");
      end else begin
         if (word !== expected[`PDP1_WORD_BITS-1:0])
            report_mismatch("word", expected, 32'(word));
         held = word;
         repeat (3) begin
            @(negedge CLK_50M);
            if (!word_valid || !tape_wait)
               report_problem("word_valid or tape_wait fell before the word was taken");
            if (word !== held)
               report_mismatch("word", 32'(held), 32'(word));
         end
      end
   endtask

   task automatic take_word();
      word_taken = 1'b1;
      @(negedge CLK_50M);
      word_taken = 1'b0;
      if (word_valid !== 1'b0)
         report_mismatch("word_valid", 32'd0, 32'(word_valid));
      if (tape_wait !== 1'b0)
         report_mismatch("tape_wait", 32'd0, 32'(tape_wait));
   endtask

   task automatic expect_mem_write(input logic [31:0] addr, input logic [31:0] data);
      int n;
      for (n = 0; n < WAIT_CYCLES && !mem_wr; n++) @(negedge CLK_50M);
      if (!mem_wr) begin
         report_problem("mem_wr never pulsed for an expected dio line");
      end else begin
         if (mem_addr !== addr[`PDP1_ADDR_BITS-1:0])
            report_mismatch("mem_addr", addr, 32'(mem_addr));
         if (mem_data !== data[`PDP1_WORD_BITS-1:0])
            report_mismatch("mem_data", data, 32'(mem_data));
         @(negedge CLK_50M);
         if (mem_wr !== 1'b0)
            report_mismatch("mem_wr", 32'd0, 32'(mem_wr));
      end
   endtask

   // Nothing may come out of a discarded line
   task automatic expect_quiet(input logic [31:0] cycles);
      repeat (cycles) begin
         @(negedge CLK_50M);
         if (mem_wr !== 1'b0 || word_valid !== 1'b0)
            report_problem("a discarded line produced a memory write or a word");
      end
   endtask

   // ======================================================================
   // Gamepad
   // ======================================================================

   // Four bits per player, ccw then cw then thrust then fire
   function automatic logic [3:0] player_bits(input logic [15:0] joy);
      logic hyper;
      hyper          = joy[`JOY_HYPER];
      player_bits[3] = joy[1] | joy[`JOY_LEFT] | hyper;
      player_bits[2] = joy[0] | joy[`JOY_RIGHT] | hyper;
      player_bits[1] = joy[2] | joy[`JOY_THRUST];
      player_bits[0] = joy[3] | joy[`JOY_FIRE];
   endfunction

   function automatic logic [`PDP1_WORD_BITS-1:0] expected_io_word(input logic [15:0] j0,
                                                                   input logic [15:0] j1);
      expected_io_word = {player_bits(j0), 10'd0, player_bits(j1)};
   endfunction

   task automatic check_gamepad(input int runs);
      logic [31:0]                rnd;
      logic [`PDP1_WORD_BITS-1:0] expected;
      int                         n;
      // Hyperspace alone reads as both turns for each player
      joystick_0             = 16'h0000;
      joystick_0[`JOY_HYPER] = 1'b1;
      joystick_1             = joystick_0;
      @(negedge CLK_50M);
      if (io_word !== 18'h3000c)
         report_mismatch("io_word", 32'h3000c, 32'(io_word));
      for (n = 0; n < runs; n++) begin
         rnd        = $urandom;
         joystick_0 = rnd[15:0];
         joystick_1 = rnd[31:16];
         expected   = expected_io_word(joystick_0, joystick_1);
         @(negedge CLK_50M);
         if (io_word !== expected)
            report_mismatch("io_word", 32'(expected), 32'(io_word));
      end
   endtask

   // ======================================================================
   // Record decoder
   // ======================================================================
   task automatic run_record(input int fd, input logic [7:0] cmd);
      logic [31:0] a;
      logic [31:0] b;
      int          rc;
      int          n;
      rc = 1;
      if (!(cmd inside {"E", "X", "T"}))
         rc = $fscanf(fd, "%h", a);
      if (cmd == "M" && rc == 1)
         rc = $fscanf(fd, "%h", b);
      if (rc != 1) begin
         report_problem($sformatf("record %c is missing its arguments", cmd));
      end else begin
         case (cmd)
            "B": begin
               for (n = 0; n < int'(a); n++) begin
                  if ($fscanf(fd, "%h", b) == 1)
                     send_byte(b[7:0]);
                  else
                     report_problem("byte record is shorter than its count");
               end
            end
            "D": set_download(a[0]);
            "E": pulse_mode(1'b1);
            "X": pulse_mode(1'b0);
            "T": take_word();
            "C": repeat (a) @(negedge CLK_50M);
            "W": expect_word(a);
            "M": expect_mem_write(a, b);
            "N": expect_quiet(a);
            "G": check_gamepad(int'(a));
            "S": if (start_addr !== a[`PDP1_ADDR_BITS-1:0])
                    report_mismatch("start_addr", a, 32'(start_addr));
            "R": if (rim_active !== a[0])
                    report_mismatch("rim_active", a, 32'(rim_active));
            "V": begin
               if (word_valid !== a[0])
                  report_mismatch("word_valid", a, 32'(word_valid));
               if (tape_wait !== a[0])
                  report_mismatch("tape_wait", a, 32'(tape_wait));
            end
            default: report_problem($sformatf("unknown record type %c", cmd));
         endcase
      end
   endtask

   // ======================================================================
   // Main sequence
   // ======================================================================
   initial begin
      int               fd;
      int               rc;
      logic [7:0]       cmd;
      logic [8*128-1:0] line_buf;
      bit               done;
      CLK_50M       = 1'b0;
      arst_n        = 1'b0;
      tape_download = 1'b0;
      tape_wr       = 1'b0;
      tape_byte     = 8'h00;
      rim_enable    = 1'b0;
      rim_disable   = 1'b0;
      word_taken    = 1'b0;
      joystick_0    = 16'h0000;
      joystick_1    = 16'h0000;
      void'($urandom(32'h1ccd_ce1c));

      // Line count of the test file sets the watchdog budget
      fd = $fopen(TEST_FILE, "r");
      if (fd == 0) begin
         report_problem("cannot open the test file");
      end else begin
         while ($fgets(line_buf, fd) != 0)
            record_lines++;
         $fclose(fd);
      end

      repeat (8) @(posedge CLK_50M);
      @(negedge CLK_50M);
      arst_n = 1'b1;
      @(negedge CLK_50M);
      if (mem_wr !== 1'b0 || tape_wait !== 1'b0)
         report_problem("mem_wr or tape_wait is high after reset");
      if (io_word !== '0)
         report_mismatch("io_word", 32'd0, 32'(io_word));

      fd   = $fopen(TEST_FILE, "r");
      done = (fd == 0);
      while (!done) begin
         rc = $fscanf(fd, " %c", cmd);
         if (rc != 1)
            done = 1'b1;
         else if (cmd == "#")
            rc = $fgets(line_buf, fd);
         else
            run_record(fd, cmd);
      end
      if (fd != 0)
         $fclose(fd);

      @(negedge CLK_50M);
      $display("Tape reader checks finished with %0d value errors and %0d other errors",
               value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

   // Watchdog, sized from the number of lines in the test file
   initial begin
      wait (record_lines > 0);
      repeat (record_lines * CYCLES_PER_RECORD + 8) @(posedge CLK_50M);
      $display("ERROR t=%0t watchdog expired before the tests finished", $time);
      $display("** FAIL **");
      $finish;
   end

endmodule

`default_nettype wire

// ==== rtl/pdp1_tape_top.sv ====
// PDP-1 tape reader front end and Spacewar gamepad top level
`default_nettype none
`timescale 1ns/1ps

`include "pdp1_tape_defines.svh"

module pdp1_tape_top (
   input  logic                       CLK_50M,
   input  logic                       arst_n,

   // Byte source, waits while a word is held for the CPU
   input  logic                       tape_download,
   input  logic                       tape_wr,
   input  logic [7:0]                 tape_byte,
   output logic                       tape_wait,

   // Read-in mode control
   input  logic                       rim_enable,
   input  logic                       rim_disable,
   output logic                       rim_active,

   // Word handoff to the CPU
   output logic                       word_valid,
   output logic [`PDP1_WORD_BITS-1:0] word,
   input  logic                       word_taken,

   // Memory write port used by dio lines
   output logic                       mem_wr,
   output logic [`PDP1_ADDR_BITS-1:0] mem_addr,
   output logic [`PDP1_WORD_BITS-1:0] mem_data,
   output logic [`PDP1_ADDR_BITS-1:0] start_addr,

   // Gamepad
   input  logic [15:0]                joystick_0,
   input  logic [15:0]                joystick_1,
   output logic [`PDP1_WORD_BITS-1:0] io_word
);

   // Assembled lines and back-pressure between the two tape blocks
   tape_line_if lines_if ();

   tape_frame_assembler assembler_i (
      .CLK_50M       (CLK_50M),
      .arst_n        (arst_n),
      .tape_download (tape_download),
      .tape_wr       (tape_wr),
      .tape_byte     (tape_byte),
      .lines         (lines_if.assembler)
   );

   tape_loader loader_i (
      .CLK_50M       (CLK_50M),
      .arst_n        (arst_n),
      .tape_download (tape_download),
      .rim_enable    (rim_enable),
      .rim_disable   (rim_disable),
      .word_taken    (word_taken),
      .lines         (lines_if.loader),
      .tape_wait     (tape_wait),
      .rim_active    (rim_active),
      .mem_wr        (mem_wr),
      .mem_addr      (mem_addr),
      .mem_data      (mem_data),
      .start_addr    (start_addr),
      .word_valid    (word_valid),
      .word          (word)
   );

   spacewar_gamepad gamepad_i (
      .CLK_50M    (CLK_50M),
      .arst_n     (arst_n),
      .joystick_0 (joystick_0),
      .joystick_1 (joystick_1),
      .io_word    (io_word)
   );

endmodule

`default_nettype wire

// ==== rtl/spacewar_gamepad.sv ====
// Spacewar gamepad mapper from two joysticks to the registered PDP-1 IO word
`default_nettype none
`timescale 1ns/1ps

`include "pdp1_tape_defines.svh"

module spacewar_gamepad (
   input  logic                       CLK_50M,
   input  logic                       arst_n,
   input  logic [15:0]                joystick_0,
   input  logic [15:0]                joystick_1,
   output logic [`PDP1_WORD_BITS-1:0] io_word
);

   // Direction pad bits of the joystick word
   localparam int PAD_RIGHT = 0;
   localparam int PAD_LEFT  = 1;
   localparam int PAD_DOWN  = 2;
   localparam int PAD_UP    = 3;

   // Four control bits per player in the order ccw, cw, thrust, fire.
   // Hyperspace is read by the game as both turns pressed at once
   function automatic logic [3:0] map_player(input logic [15:0] joy);
      map_player = {joy[PAD_LEFT]  | joy[`JOY_LEFT]  | joy[`JOY_HYPER],
                    joy[PAD_RIGHT] | joy[`JOY_RIGHT] | joy[`JOY_HYPER],
                    joy[PAD_DOWN]  | joy[`JOY_THRUST],
                    joy[PAD_UP]    | joy[`JOY_FIRE]};
   endfunction

   // Player 0 in the top nibble, player 1 in the bottom one
   always_ff @(posedge CLK_50M or negedge arst_n) begin
      if (!arst_n) begin
         io_word <= '0;
      end else begin
         io_word <= {map_player(joystick_0),
                     {(`PDP1_WORD_BITS-8){1'b0}},
                     map_player(joystick_1)};
      end
   end

endmodule

`default_nettype wire

// ==== rtl/tape_loader.sv ====
// Tape loader that turns assembled lines into CPU words, RIM memory writes and jumps
`default_nettype none
`timescale 1ns/1ps

`include "pdp1_tape_defines.svh"

module tape_loader (
   input  logic                       CLK_50M,
   input  logic                       arst_n,
   input  logic                       tape_download,
   input  logic                       rim_enable,
   input  logic                       rim_disable,
   input  logic                       word_taken,
   tape_line_if.loader                lines,
   output logic                       tape_wait,
   output logic                       rim_active,
   output logic                       mem_wr,
   output logic [`PDP1_ADDR_BITS-1:0] mem_addr,
   output logic [`PDP1_WORD_BITS-1:0] mem_data,
   output logic [`PDP1_ADDR_BITS-1:0] start_addr,
   output logic                       word_valid,
   output logic [`PDP1_WORD_BITS-1:0] word
);

   logic                       rim_q;
   logic                       pending_q;
   logic                       mem_wr_q;
   logic [`PDP1_ADDR_BITS-1:0] start_q;
   logic [`PDP1_ADDR_BITS-1:0] mem_addr_q;
   logic [`PDP1_WORD_BITS-1:0] mem_data_q;
   logic [`PDP1_WORD_BITS-1:0] word_q;
   logic                       take_bin;
   logic                       is_dio;
   logic                       is_jmp;
   logic                       clear_word;

   // ======================================================================
   // Line decode
   // ======================================================================

   // In binary mode every line is a word for the CPU
   // The assembler stalls while a word waits, so no new line arrives then
   assign take_bin = lines.line_strobe && !rim_q;

   // Read-in lines are decoded through the instruction view of the union
   assign is_dio = lines.line_strobe && rim_q
                && (lines.line.rim.opcode == `PDP1_OP_DIO);
   assign is_jmp = lines.line_strobe && rim_q
                && (lines.line.rim.opcode == `PDP1_OP_JMP);

   // Leaving the download or leaving RIM drops whatever word is pending
   assign clear_word = !tape_download || rim_disable;

   // ======================================================================
   // Control state
   // ======================================================================
   always_ff @(posedge CLK_50M or negedge arst_n) begin
      if (!arst_n) begin
         rim_q     <= 1'b0;
         pending_q <= 1'b0;
         mem_wr_q  <= 1'b0;
         start_q   <= `PDP1_DEFAULT_START;
      end else begin
         // Memory write strobe lasts exactly one cycle per dio line
         mem_wr_q <= is_dio;

         // A jmp line ends the read-in and sets where the CPU starts
         if (is_jmp) begin
            start_q <= lines.line.rim.addr;
         end

         if (rim_disable || is_jmp) begin
            rim_q <= 1'b0;
         end else if (rim_enable) begin
            rim_q <= 1'b1;
         end

         // Pending word falls one cycle after the CPU takes it
         if (clear_word) begin
            pending_q <= 1'b0;
         end else if (take_bin || is_jmp) begin
            pending_q <= 1'b1;
         end else if (word_taken) begin
            pending_q <= 1'b0;
         end
      end
   end

   // ======================================================================
   // Payload registers
   // ======================================================================
   always_ff @(posedge CLK_50M) begin
      if (take_bin) begin
         word_q <= lines.line.raw.lo;
      end else if (is_jmp) begin
         word_q <= lines.line.rim.data;
      end

      if (is_dio) begin
         mem_addr_q <= lines.line.rim.addr;
         mem_data_q <= lines.line.rim.data;
      end
   end

   // The same pending flag stalls the assembler and the byte source
   assign lines.hold     = pending_q;
   assign lines.rim_mode = rim_q;
   assign tape_wait      = pending_q;
   assign word_valid     = pending_q;
   assign word           = word_q;
   assign rim_active     = rim_q;
   assign mem_wr         = mem_wr_q;
   assign mem_addr       = mem_addr_q;
   assign mem_data       = mem_data_q;
   assign start_addr     = start_q;

   a_mem_wr_single : assert property (
      @(posedge CLK_50M) disable iff (!arst_n)
      mem_wr |=> !mem_wr
   ) else $error("mem_wr held for more than one cycle");

   // Offered word must not move until the CPU has taken it
   a_word_stable : assert property (
      @(posedge CLK_50M) disable iff (!arst_n)
      word_valid |=> (!word_valid || $stable(word))
   ) else $error("word changed while word_valid was high");

endmodule

`default_nettype wire

// ==== rtl/tape_frame_assembler.sv ====
// Tape frame assembler that packs 6-bit data frames into binary words or RIM lines
`default_nettype none
`timescale 1ns/1ps

`include "pdp1_tape_defines.svh"

module tape_frame_assembler (
   input  logic                 CLK_50M,
   input  logic                 arst_n,
   input  logic                 tape_download,
   input  logic                 tape_wr,
   input  logic [7:0]           tape_byte,
   tape_line_if.assembler       lines
);
   import pdp1_tape_pkg::*;

   // Counter must reach the larger of the two frame totals
   localparam int CNT_BITS = $clog2(`PDP1_RIM_FRAMES + 1);

   logic                 dl_q;
   logic                 dl_rise;
   logic                 accept;
   logic                 line_done;
   logic [CNT_BITS-1:0]  frame_total;
   logic [CNT_BITS-1:0]  frame_cnt;
   logic [LINE_BITS-1:0] shift_q;

   // ======================================================================
   // Byte acceptance
   // ======================================================================

   // Only bytes with bit 7 set carry data, the rest are skipped silently
   assign accept  = tape_wr && !lines.hold && tape_byte[7];
   assign dl_rise = tape_download && !dl_q;

   // Three frames for a binary word, six for a read-in line
   assign frame_total = lines.rim_mode ? CNT_BITS'(`PDP1_RIM_FRAMES)
                                       : CNT_BITS'(`PDP1_BIN_FRAMES);

   // The count may exceed the total if the mode drops mid-line
   assign line_done = (frame_cnt >= frame_total);

   // Full line is presented for the single cycle after its last frame
   assign lines.line_strobe = line_done;
   assign lines.line        = shift_q;

   // ======================================================================
   // Frame counter
   // ======================================================================
   always_ff @(posedge CLK_50M or negedge arst_n) begin
      if (!arst_n) begin
         dl_q      <= 1'b0;
         frame_cnt <= '0;
      end else begin
         dl_q <= tape_download;
         // A fresh download throws away any partial line
         if (dl_rise) begin
            frame_cnt <= '0;
         end else if (line_done) begin
            // A byte arriving in the strobe cycle starts the next line
            frame_cnt <= accept ? CNT_BITS'(1) : '0;
         end else if (accept) begin
            frame_cnt <= frame_cnt + 1'b1;
         end
      end
   end

   // ======================================================================
   // Shift register, first frame ends up in the highest bits
   // ======================================================================
   always_ff @(posedge CLK_50M) begin
      if (dl_rise) begin
         shift_q <= '0;
      end else if (line_done) begin
         shift_q <= accept ? {{(LINE_BITS-`PDP1_FRAME_BITS){1'b0}},
                              tape_byte[`PDP1_FRAME_BITS-1:0]}
                           : '0;
      end else if (accept) begin
         shift_q <= {shift_q[LINE_BITS-`PDP1_FRAME_BITS-1:0],
                     tape_byte[`PDP1_FRAME_BITS-1:0]};
      end
   end

   // While the loader holds a word the source is told to wait, so no
   // data byte should be offered until the CPU has taken it
   a_no_byte_on_hold : assert property (
      @(posedge CLK_50M) disable iff (!arst_n)
      lines.hold |-> !(tape_wr && tape_byte[7])
   ) else $error("Tape data byte offered while the loader holds a word");

endmodule

`default_nettype wire

// ==== rtl/tape_line_if.sv ====
// Line channel from the frame assembler to the loader, with back-pressure
`default_nettype none
`timescale 1ns/1ps

interface tape_line_if;
   import pdp1_tape_pkg::*;

   // Loader side, current mode sets the frame total per line
   logic       rim_mode;
   // Loader side, high while a word waits for the CPU
   logic       hold;
   // Assembler side, line is only meaningful while this is high
   logic       line_strobe;
   tape_line_u line;

   modport assembler (
      input  rim_mode,
      input  hold,
      output line_strobe,
      output line
   );

   modport loader (
      output rim_mode,
      output hold,
      input  line_strobe,
      input  line
   );
endinterface

`default_nettype wire

// ==== rtl/pdp1_tape_pkg.sv ====
// Tape reader types: the 36-bit assembled line and its two decodings
`default_nettype none

package pdp1_tape_pkg;
   `include "pdp1_tape_defines.svh"

   // A full read-in line is six frames wide
   localparam int LINE_BITS = `PDP1_RIM_FRAMES * `PDP1_FRAME_BITS;

   // RIM view, instruction field first as it comes off the tape
   typedef struct packed {
      logic [`PDP1_FRAME_BITS-1:0] opcode;
      logic [`PDP1_ADDR_BITS-1:0]  addr;
      logic [`PDP1_WORD_BITS-1:0]  data;
   } rim_line_t;

   // Raw view as two PDP-1 words, binary mode uses only the low one
   typedef struct packed {
      logic [`PDP1_WORD_BITS-1:0] hi;
      logic [`PDP1_WORD_BITS-1:0] lo;
   } raw_line_t;

   typedef union packed {
      rim_line_t rim;
      raw_line_t raw;
   } tape_line_u;
endpackage

`default_nettype wire

// ==== rtl/pdp1_tape_defines.svh ====
// PDP-1 tape reader constants for frame layout, RIM opcodes and gamepad buttons
`ifndef PDP1_TAPE_DEFINES_SVH
`define PDP1_TAPE_DEFINES_SVH

// Each tape byte with bit 7 set carries one 6-bit frame
`define PDP1_FRAME_BITS    6
`define PDP1_WORD_BITS     18
`define PDP1_ADDR_BITS     12

// Frames per binary word and per read-in line
`define PDP1_BIN_FRAMES    3
`define PDP1_RIM_FRAMES    6

// Read-in mode understands only these two instructions
`define PDP1_OP_DIO        6'o32
`define PDP1_OP_JMP        6'o60
`define PDP1_DEFAULT_START 12'o4

// Button bits above the direction pad, which sits in bits 3..0
`define JOY_LEFT           4
`define JOY_RIGHT          5
`define JOY_THRUST         6
`define JOY_FIRE           7
`define JOY_HYPER          8
`endif
